// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int addr_width     = 16;
    localparam int data_width     = 32;
    localparam int itag_width     = 2;
    localparam int dcr_addr_width = 4;
    localparam int dcr_data_width = 32;

    // Configuration register map
    localparam logic [dcr_addr_width-1:0] dcr_start_pc = 4'h1;
    localparam logic [dcr_addr_width-1:0] dcr_acc_init = 4'h2;
    localparam logic [dcr_addr_width-1:0] dcr_launch   = 4'h3;

    // Opcode lives in the top nibble of an instruction word
    typedef enum logic [3:0] {
        op_nop   = 4'h0,
        op_load  = 4'h1,
        op_add   = 4'h2,
        op_store = 4'h3,
        op_jump  = 4'h4,
        op_halt  = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_wait_mem,
        st_drain
    } ctrl_state_t;

    typedef struct packed {
        opcode_t                           opcode;
        logic [data_width-4-addr_width-1:0] pad;
        logic [addr_width-1:0]             operand;
    } instr_t;

    typedef struct packed {
        logic [dcr_addr_width-1:0] addr;
        logic [dcr_data_width-1:0] data;
    } dcr_write_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [itag_width-1:0] tag;
    } icache_req_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [itag_width-1:0] tag;
    } icache_rsp_t;

    // rw set means a write
    typedef struct packed {
        logic                  rw;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } dcache_req_t;

    typedef struct packed {
        logic                  is_store;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } lsu_op_t;

endpackage

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   redirect,
    input  wire [addr_width-1:0]  redirect_pc,
    input  wire                   run,
    output logic                  req_valid,
    output icache_req_t           req,
    input  wire                   req_ready,
    input  wire                   rsp_valid,
    input  wire icache_rsp_t      rsp,
    output logic                  rsp_ready,
    output logic                  instr_valid,
    output instr_t                instr,
    input  wire                   instr_ready,
    output logic                  idle
);

    logic [addr_width-1:0] pc;
    logic [itag_width-1:0] epoch;
    logic [1:0]            inflight;
    logic                  req_valid_q;
    icache_req_t           req_q;
    instr_t                queue [2];
    logic                  wr_ptr;
    logic                  rd_ptr;
    logic [1:0]            count;

    logic                  req_fire;
    logic                  keep;
    logic                  pop;
    logic                  issue;
    logic [1:0]            count_eff;
    logic [addr_width-1:0] issue_addr;
    logic [itag_width-1:0] issue_tag;

    assign req_fire = req_valid_q && req_ready;

    // Responses from an older epoch only retire their outstanding slot
    assign keep = rsp_valid && !redirect && (rsp.tag == epoch);
    assign pop  = instr_valid && instr_ready;

    // A redirect empties the queue, so its space is free for the new stream
    assign count_eff  = redirect ? 2'd0 : count;
    assign issue      = run && !req_valid_q &&
                        (({1'b0, inflight} + {1'b0, count_eff}) < 3'd2);
    assign issue_addr = redirect ? redirect_pc : pc;
    assign issue_tag  = redirect ? epoch + itag_width'(1) : epoch;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= '0;
            epoch       <= '0;
            inflight    <= '0;
            req_valid_q <= 1'b0;
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
            count       <= '0;
        end else begin
            if (redirect) begin
                epoch <= epoch + itag_width'(1);
            end
            if (issue) begin
                req_valid_q <= 1'b1;
                pc          <= issue_addr + addr_width'(1);
            end else begin
                if (req_fire) begin
                    req_valid_q <= 1'b0;
                end
                if (redirect) begin
                    pc <= redirect_pc;
                end
            end
            inflight <= inflight + {1'b0, req_fire} - {1'b0, rsp_valid};
            if (redirect) begin
                wr_ptr <= 1'b0;
                rd_ptr <= 1'b0;
                count  <= '0;
            end else begin
                if (keep) begin
                    wr_ptr <= ~wr_ptr;
                end
                if (pop) begin
                    rd_ptr <= ~rd_ptr;
                end
                count <= count + {1'b0, keep} - {1'b0, pop};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_q.addr <= issue_addr;
            req_q.tag  <= issue_tag;
        end
        if (keep) begin
            queue[wr_ptr] <= instr_t'(rsp.data);
        end
    end

    assign req_valid   = req_valid_q;
    assign req         = req_q;
    assign rsp_ready   = 1'b1;
    assign instr_valid = (count != 2'd0);
    assign instr       = queue[rd_ptr];
    assign idle        = (inflight == 2'd0) && !req_valid_q;

endmodule

`default_nettype wire

// File: verilog/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu import core_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   op_valid,
    input  wire lsu_op_t          op,
    output logic                  op_ready,
    output logic                  done_valid,
    output logic [data_width-1:0] load_data,
    output logic                  req_valid,
    output dcache_req_t           req,
    input  wire                   req_ready,
    input  wire                   rsp_valid,
    input  wire [data_width-1:0]  rsp_data,
    output logic                  rsp_ready
);

    logic    req_pending;
    logic    wait_rsp;
    lsu_op_t op_q;
    logic    req_fire;
    logic    rsp_fire;

    assign op_ready = !req_pending && !wait_rsp;
    assign req_fire = req_pending && req_ready;
    assign rsp_fire = rsp_valid && wait_rsp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_pending <= 1'b0;
            wait_rsp    <= 1'b0;
        end else begin
            if (op_valid && op_ready) begin
                req_pending <= 1'b1;
            end else if (req_fire) begin
                req_pending <= 1'b0;
                // Loads stay busy until their data comes back
                wait_rsp    <= !op_q.is_store;
            end else if (rsp_fire) begin
                wait_rsp <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            op_q <= op;
        end
    end

    assign req_valid  = req_pending;
    assign req.rw     = op_q.is_store;
    assign req.addr   = op_q.addr;
    assign req.data   = op_q.data;
    assign rsp_ready  = 1'b1;

    // A store is finished once the memory takes it
    assign done_valid = (req_fire && op_q.is_store) || rsp_fire;
    assign load_data  = rsp_data;

endmodule

`default_nettype wire

// File: verilog/core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module core_ctrl import core_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   dcr_valid,
    input  wire dcr_write_t       dcr,
    output logic                  fetch_redirect,
    output logic [addr_width-1:0] fetch_pc,
    output logic                  fetch_run,
    input  wire                   instr_valid,
    input  wire instr_t           instr,
    output logic                  instr_ready,
    input  wire                   fetch_idle,
    output logic                  lsu_op_valid,
    output lsu_op_t               lsu_op,
    input  wire                   lsu_op_ready,
    input  wire                   lsu_done,
    input  wire [data_width-1:0]  lsu_load_data,
    output logic                  busy
);

    logic [addr_width-1:0] start_pc;
    logic [data_width-1:0] acc_init;
    logic [data_width-1:0] acc;
    ctrl_state_t           state;
    opcode_t               pend_op;

    logic launch;
    logic exec_ok;
    logic accept;
    logic is_mem;

    assign launch = dcr_valid && (dcr.addr == dcr_launch);

    // While a redirect is in flight the queue head belongs to the old stream
    assign exec_ok = (state == st_run) && !fetch_redirect;
    assign is_mem  = instr.opcode inside {op_load, op_add, op_store};

    assign instr_ready     = exec_ok && lsu_op_ready;
    assign accept          = instr_valid && instr_ready;
    assign lsu_op_valid    = instr_valid && exec_ok && is_mem;
    assign lsu_op.is_store = (instr.opcode == op_store);
    assign lsu_op.addr     = instr.operand;
    assign lsu_op.data     = acc;

    assign fetch_run = (state == st_run) || (state == st_wait_mem);
    assign busy      = (state != st_idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_pc       <= '0;
            acc_init       <= '0;
            acc            <= '0;
            state          <= st_idle;
            pend_op        <= op_nop;
            fetch_redirect <= 1'b0;
            fetch_pc       <= '0;
        end else begin
            fetch_redirect <= 1'b0;
            if (dcr_valid && (dcr.addr == dcr_start_pc)) begin
                start_pc <= dcr.data[addr_width-1:0];
            end
            if (dcr_valid && (dcr.addr == dcr_acc_init)) begin
                acc_init <= dcr.data[data_width-1:0];
            end
            unique case (state)
                st_idle: begin
                    if (launch) begin
                        state          <= st_run;
                        acc            <= acc_init;
                        fetch_redirect <= 1'b1;
                        fetch_pc       <= start_pc;
                    end
                end
                st_run: begin
                    if (accept) begin
                        case (instr.opcode)
                            op_load, op_add, op_store: begin
                                pend_op <= instr.opcode;
                                state   <= st_wait_mem;
                            end
                            op_jump: begin
                                fetch_redirect <= 1'b1;
                                fetch_pc       <= instr.operand;
                            end
                            op_halt: state <= st_drain;
                            // NOP and unknown opcodes retire without effect
                            default: ;
                        endcase
                    end
                end
                st_wait_mem: begin
                    if (lsu_done) begin
                        if (pend_op == op_load) begin
                            acc <= lsu_load_data;
                        end else if (pend_op == op_add) begin
                            acc <= acc + lsu_load_data;
                        end
                        state <= st_run;
                    end
                end
                st_drain: begin
                    // Stale fetches must return before the core reports idle
                    if (fetch_idle && lsu_op_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  wire                      clk,
    input  wire                      arst_n,

    input  wire                      dcr_write_valid,
    input  wire [dcr_addr_width-1:0] dcr_write_addr,
    input  wire [dcr_data_width-1:0] dcr_write_data,

    output logic                     icache_req_valid,
    output logic [addr_width-1:0]    icache_req_addr,
    output logic [itag_width-1:0]    icache_req_tag,
    input  wire                      icache_req_ready,

    input  wire                      icache_rsp_valid,
    input  wire [data_width-1:0]     icache_rsp_data,
    input  wire [itag_width-1:0]     icache_rsp_tag,
    output logic                     icache_rsp_ready,

    output logic                     dcache_req_valid,
    output logic                     dcache_req_rw,
    output logic [addr_width-1:0]    dcache_req_addr,
    output logic [data_width-1:0]    dcache_req_data,
    input  wire                      dcache_req_ready,

    input  wire                      dcache_rsp_valid,
    input  wire [data_width-1:0]     dcache_rsp_data,
    output logic                     dcache_rsp_ready,

    output logic                     busy
);

    dcr_write_t            dcr_write;
    icache_req_t           icache_req;
    icache_rsp_t           icache_rsp;
    dcache_req_t           dcache_req;

    logic                  fetch_redirect;
    logic [addr_width-1:0] fetch_pc;
    logic                  fetch_run;
    logic                  fetch_idle;
    logic                  instr_valid;
    instr_t                instr;
    logic                  instr_ready;
    logic                  lsu_op_valid;
    lsu_op_t               lsu_op;
    logic                  lsu_op_ready;
    logic                  lsu_done;
    logic [data_width-1:0] lsu_load_data;

    assign dcr_write.addr  = dcr_write_addr;
    assign dcr_write.data  = dcr_write_data;

    assign icache_req_addr = icache_req.addr;
    assign icache_req_tag  = icache_req.tag;
    assign icache_rsp.data = icache_rsp_data;
    assign icache_rsp.tag  = icache_rsp_tag;

    assign dcache_req_rw   = dcache_req.rw;
    assign dcache_req_addr = dcache_req.addr;
    assign dcache_req_data = dcache_req.data;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .redirect    (fetch_redirect),
        .redirect_pc (fetch_pc),
        .run         (fetch_run),
        .req_valid   (icache_req_valid),
        .req         (icache_req),
        .req_ready   (icache_req_ready),
        .rsp_valid   (icache_rsp_valid),
        .rsp         (icache_rsp),
        .rsp_ready   (icache_rsp_ready),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .idle        (fetch_idle)
    );

    lsu i_lsu (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_valid   (lsu_op_valid),
        .op         (lsu_op),
        .op_ready   (lsu_op_ready),
        .done_valid (lsu_done),
        .load_data  (lsu_load_data),
        .req_valid  (dcache_req_valid),
        .req        (dcache_req),
        .req_ready  (dcache_req_ready),
        .rsp_valid  (dcache_rsp_valid),
        .rsp_data   (dcache_rsp_data),
        .rsp_ready  (dcache_rsp_ready)
    );

    core_ctrl i_core_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .dcr_valid      (dcr_write_valid),
        .dcr            (dcr_write),
        .fetch_redirect (fetch_redirect),
        .fetch_pc       (fetch_pc),
        .fetch_run      (fetch_run),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_ready    (instr_ready),
        .fetch_idle     (fetch_idle),
        .lsu_op_valid   (lsu_op_valid),
        .lsu_op         (lsu_op),
        .lsu_op_ready   (lsu_op_ready),
        .lsu_done       (lsu_done),
        .lsu_load_data  (lsu_load_data),
        .busy           (busy)
    );

endmodule

`default_nettype wire

// File: bench/core_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module core_top_assert import core_pkg::*; (
    input wire                  clk,
    input wire                  arst_n,
    input wire                  icache_req_valid,
    input wire [addr_width-1:0] icache_req_addr,
    input wire [itag_width-1:0] icache_req_tag,
    input wire                  icache_req_ready,
    input wire                  dcache_req_valid,
    input wire                  dcache_req_rw,
    input wire [addr_width-1:0] dcache_req_addr,
    input wire [data_width-1:0] dcache_req_data,
    input wire                  dcache_req_ready,
    input wire                  busy
);

    // A stalled request keeps its payload until the memory takes it
    icache_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (icache_req_valid && !icache_req_ready) |=>
            (icache_req_valid && $stable({icache_req_addr, icache_req_tag})))
        else $error("icache request dropped or changed while stalled");

    dcache_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (dcache_req_valid && !dcache_req_ready) |=>
            (dcache_req_valid &&
             $stable({dcache_req_rw, dcache_req_addr, dcache_req_data})))
        else $error("dcache request dropped or changed while stalled");

    reset_quiet: assert property (@(posedge clk)
        !arst_n |=> (!icache_req_valid && !dcache_req_valid && !busy))
        else $error("request valid or busy high during reset");

endmodule

bind core_top core_top_assert i_core_top_assert (.*);

`default_nettype wire

// File: bench/core_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_top_tb import core_pkg::*; ();

    typedef struct packed {
        logic [7:0]            kind;
        logic [31:0]           a;
        logic [31:0]           b;
    } golden_rec_t;

    logic                      clk;
    logic                      arst_n;
    logic                      dcr_write_valid;
    logic [dcr_addr_width-1:0] dcr_write_addr;
    logic [dcr_data_width-1:0] dcr_write_data;
    logic                      icache_req_valid;
    logic [addr_width-1:0]     icache_req_addr;
    logic [itag_width-1:0]     icache_req_tag;
    logic                      icache_req_ready = 1'b0;
    logic                      icache_rsp_valid = 1'b0;
    logic [data_width-1:0]     icache_rsp_data  = '0;
    logic [itag_width-1:0]     icache_rsp_tag   = '0;
    logic                      icache_rsp_ready;
    logic                      dcache_req_valid;
    logic                      dcache_req_rw;
    logic [addr_width-1:0]     dcache_req_addr;
    logic [data_width-1:0]     dcache_req_data;
    logic                      dcache_req_ready = 1'b0;
    logic                      dcache_rsp_valid = 1'b0;
    logic [data_width-1:0]     dcache_rsp_data  = '0;
    logic                      dcache_rsp_ready;
    logic                      busy;

    logic [data_width-1:0]     imem [2**addr_width];
    logic [data_width-1:0]     dmem [2**addr_width];
    icache_rsp_t               ic_rsp_q [$];
    int                        ic_due_q [$];
    logic [data_width-1:0]     dc_rsp_q [$];
    int                        dc_due_q [$];
    dcache_req_t               exp_q [$];
    golden_rec_t               golden_q [$];
    int                        golden_lines = 0;
    logic                      golden_loaded = 1'b0;
    int                        mem_cycle = 0;
    integer                    seed = 32'h5650;
    dcache_req_t               got_store;

    core_top i_core_top (
        .clk              (clk),
        .arst_n           (arst_n),
        .dcr_write_valid  (dcr_write_valid),
        .dcr_write_addr   (dcr_write_addr),
        .dcr_write_data   (dcr_write_data),
        .icache_req_valid (icache_req_valid),
        .icache_req_addr  (icache_req_addr),
        .icache_req_tag   (icache_req_tag),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_data  (icache_rsp_data),
        .icache_rsp_tag   (icache_rsp_tag),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_req_addr  (dcache_req_addr),
        .dcache_req_data  (dcache_req_data),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_data  (dcache_rsp_data),
        .dcache_rsp_ready (dcache_rsp_ready),
        .busy             (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %b got %b", $time, name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_store(input dcache_req_t expected, input dcache_req_t actual);
        if (actual !== expected) begin
            $display("Error at %0t: dcache_req rw/addr/data expected %b/%h/%h got %b/%h/%h",
                     $time, expected.rw, expected.addr, expected.data,
                     actual.rw, actual.addr, actual.data);
            report_failure();
        end
    endtask

    task automatic fill_memories();
        for (int a = 0; a < 2**addr_width; a++) begin
            // Unwritten code reads as HALT and unwritten data echoes its address
            imem[a[addr_width-1:0]] = {4'hf, 12'h000, a[addr_width-1:0]};
            dmem[a[addr_width-1:0]] = {~a[addr_width-1:0], a[addr_width-1:0]};
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        string       rest;
        fd = $fopen("bench/program_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file bench/program_golden.txt");
            report_failure();
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                golden_lines++;
                a = '0;
                b = '0;
                if (kind == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    if (kind != "E") begin
                        n = $fscanf(fd, "%h %h", a, b);
                        if (n != 2) begin
                            $display("Golden record of kind %c is missing its fields", kind);
                            report_failure();
                        end
                    end
                    golden_q.push_back({kind, a, b});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_dcr(input logic [dcr_addr_width-1:0] addr,
                             input logic [dcr_data_width-1:0] data);
        @(posedge clk);
        dcr_write_valid <= 1'b1;
        dcr_write_addr  <= addr;
        dcr_write_data  <= data;
        @(posedge clk);
        dcr_write_valid <= 1'b0;
    endtask

    task automatic run_launch(input int test_num, input logic [addr_width-1:0] pc,
                              input logic [data_width-1:0] acc);
        write_dcr(dcr_start_pc, {{(dcr_data_width-addr_width){1'b0}}, pc});
        write_dcr(dcr_acc_init, acc);
        @(negedge clk);
        check_flag("busy", 1'b0, busy);
        write_dcr(dcr_launch, '0);
        @(negedge clk);
        check_flag("busy", 1'b1, busy);
        @(negedge clk);
        check_flag("icache_req_valid", 1'b1, icache_req_valid);
        while (busy === 1'b1) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("Test %0d ended with %0d expected stores missing", test_num, exp_q.size());
            report_failure();
        end else begin
            $display("Test %0d finished, launch at %h with accumulator %h", test_num, pc, acc);
        end
    endtask

    // Instruction and data memory models drawing on one random sequence
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_cycle = 0;
            ic_rsp_q.delete();
            ic_due_q.delete();
            dc_rsp_q.delete();
            dc_due_q.delete();
            icache_req_ready <= 1'b0;
            icache_rsp_valid <= 1'b0;
            dcache_req_ready <= 1'b0;
            dcache_rsp_valid <= 1'b0;
        end else begin
            mem_cycle = mem_cycle + 1;
            if (!busy) begin
                check_flag("icache_req_valid", 1'b0, icache_req_valid);
                check_flag("dcache_req_valid", 1'b0, dcache_req_valid);
            end
            if (icache_rsp_valid) begin
                check_flag("icache_rsp_ready", 1'b1, icache_rsp_ready);
                ic_rsp_q.delete(0);
                ic_due_q.delete(0);
            end
            if (icache_req_valid && icache_req_ready) begin
                ic_rsp_q.push_back({imem[icache_req_addr], icache_req_tag});
                ic_due_q.push_back(mem_cycle + ($random(seed) & 3));
            end
            if (dcache_rsp_valid) begin
                check_flag("dcache_rsp_ready", 1'b1, dcache_rsp_ready);
                dc_rsp_q.delete(0);
                dc_due_q.delete(0);
            end
            if (dcache_req_valid && dcache_req_ready) begin
                if (dcache_req_rw) begin
                    dmem[dcache_req_addr] = dcache_req_data;
                    got_store = {dcache_req_rw, dcache_req_addr, dcache_req_data};
                    if (exp_q.size() == 0) begin
                        $display("Unexpected store to %h with data %h at %0t",
                                 dcache_req_addr, dcache_req_data, $time);
                        report_failure();
                    end else begin
                        check_store(exp_q.pop_front(), got_store);
                    end
                end else begin
                    dc_rsp_q.push_back(dmem[dcache_req_addr]);
                    dc_due_q.push_back(mem_cycle + ($random(seed) & 3));
                end
            end
            icache_req_ready <= (($random(seed) & 3) != 0);
            dcache_req_ready <= (($random(seed) & 3) != 0);
            // The head response is presented once its delay has run out
            if (ic_rsp_q.size() != 0 && ic_due_q[0] <= mem_cycle) begin
                icache_rsp_valid <= 1'b1;
                icache_rsp_data  <= ic_rsp_q[0].data;
                icache_rsp_tag   <= ic_rsp_q[0].tag;
            end else begin
                icache_rsp_valid <= 1'b0;
            end
            if (dc_rsp_q.size() != 0 && dc_due_q[0] <= mem_cycle) begin
                dcache_rsp_valid <= 1'b1;
                dcache_rsp_data  <= dc_rsp_q[0];
            end else begin
                dcache_rsp_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (golden_loaded);
        limit = golden_lines * 200;
        repeat (limit) @(posedge clk);
        $display("The run timed out after %0d clock cycles", limit);
        report_failure();
    end

    initial begin : main
        golden_rec_t           rec;
        logic [addr_width-1:0] launch_pc;
        logic [data_width-1:0] launch_acc;
        int                    test_num;
        arst_n          = 1'b0;
        dcr_write_valid = 1'b0;
        dcr_write_addr  = '0;
        dcr_write_data  = '0;
        launch_pc       = '0;
        launch_acc      = '0;
        test_num        = 0;
        fill_memories();
        load_golden();
        golden_loaded = 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("busy", 1'b0, busy);
        check_flag("icache_req_valid", 1'b0, icache_req_valid);
        check_flag("dcache_req_valid", 1'b0, dcache_req_valid);
        foreach (golden_q[i]) begin
            rec = golden_q[i];
            case (rec.kind)
                "P": imem[rec.a[addr_width-1:0]] = rec.b;
                "D": dmem[rec.a[addr_width-1:0]] = rec.b;
                "L": begin
                    launch_pc  = rec.a[addr_width-1:0];
                    launch_acc = rec.b;
                end
                "S": exp_q.push_back({1'b1, rec.a[addr_width-1:0], rec.b});
                "E": begin
                    test_num++;
                    run_launch(test_num, launch_pc, launch_acc);
                end
                default: ;
            endcase
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected stores were never seen", exp_q.size());
            report_failure();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/lsu.sv
verilog/core_ctrl.sv
verilog/core_top.sv
bench/core_top_assert.sv
bench/core_top_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module core_top_tb

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module core_top_tb \
		--Mdir obj_dir -o core_top_tb
	./obj_dir/core_top_tb

clean:
	rm -rf obj_dir

// File: bench/program_golden.txt
# Each line holds a kind letter, then an address and a value in hex
# P instruction word, D data word, L start address and accumulator, S expected store, E launch
# Straight-line LOAD, ADD and STORE
D 0100 00000005
D 0101 00000007
D 0102 00001000
P 0010 30000200
P 0011 20000100
P 0012 20000101
P 0013 30000201
P 0014 10000102
P 0015 20000100
P 0016 00000000
P 0017 30000202
P 0018 f0000000
L 0010 00000003
S 0200 00000003
S 0201 0000000f
S 0202 00001005
E
# JUMP over STORE instructions that were already prefetched
D 0110 00000020
D 0111 fffffff0
P 0040 20000110
P 0041 40000045
P 0042 30000300
P 0043 30000301
P 0044 30000302
P 0045 30000210
P 0046 20000111
P 0047 30000211
P 0048 f0000000
L 0040 00000011
S 0210 00000031
S 0211 00000021
E
# New start address and accumulator, reading back an earlier store
P 0080 30000220
P 0081 20000201
P 0082 30000221
P 0083 10000202
P 0084 40000087
P 0085 30000302
P 0086 00000000
P 0087 20000100
P 0088 30000222
P 0089 f0000000
L 0080 12345678
S 0220 12345678
S 0221 12345687
S 0222 0000100a
E
# First program again with another accumulator
L 0010 00000100
S 0200 00000100
S 0201 0000010c
S 0202 00001005
E
